//--- hw/ras_settings.svh
`ifndef RAS_SETTINGS_SVH
`define RAS_SETTINGS_SVH

// width of pc, link and predicted target addresses
`define RAS_XLEN 32

// number of return address entries
// must be a power of two, 2 or more, so the pointer wraps cleanly
`define RAS_DEPTH 16

`endif

//--- hw/ras_pkg.sv
`include "ras_settings.svh"

package ras_pkg;

	// pc, link address and predicted return target
	typedef logic [`RAS_XLEN-1:0] addr_t;

	// architectural register number, x0 to x31
	typedef logic [4:0] reg_index_t;

	// major opcodes the predictor cares about
	// everything else decodes to OP_OTHER
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_OTHER  = 7'b0000000
	} opcode_t;

	// stack pointer, wraps around the circular array
	typedef logic [$clog2(`RAS_DEPTH)-1:0] depth_t;

	// entry counter, one bit wider so a full stack is representable
	typedef logic [$clog2(`RAS_DEPTH):0] count_t;

endpackage

//--- hw/jump_decode.sv
module jump_decode
	import ras_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic instr_valid,
	input logic [31:0] instr,
	input addr_t pc,

	// instruction kind, all low for an invalid slot
	output logic branch,
	output logic jump,
	output logic jalr,
	// jalr target made deterministic by a preceding lui/auipc
	output logic jalr_fold,

	output reg_index_t rs1_index,
	output reg_index_t rd_index,

	// return address a call would push
	output addr_t link_address
);

	opcode_t kind;
	logic is_upper;

	// fold memory
	// set when the last valid instruction was lui/auipc writing a real register
	logic upper_valid;
	reg_index_t upper_rd;

	// map the raw opcode onto the kinds we track
	always_comb begin
		case (instr[6:0])
			OP_LUI: begin
				kind = OP_LUI;
			end
			OP_AUIPC: begin
				kind = OP_AUIPC;
			end
			OP_JAL: begin
				kind = OP_JAL;
			end
			OP_JALR: begin
				kind = OP_JALR;
			end
			OP_BRANCH: begin
				kind = OP_BRANCH;
			end
			default: begin
				kind = OP_OTHER;
			end
		endcase
	end

	// register fields sit at the same bits in every format we use
	// jal has no rs1, but control only reads rs1 for jalr
	assign rs1_index = instr[19:15];
	assign rd_index = instr[11:7];

	// call return address, next sequential instruction
	assign link_address = pc + addr_t'(4);

	// kind outputs qualified by valid
	assign branch = instr_valid && (kind == OP_BRANCH);
	assign jalr = instr_valid && (kind == OP_JALR);
	// jal and jalr both count as jumps
	assign jump = instr_valid && ((kind == OP_JAL) || (kind == OP_JALR));

	// lui/auipc into x0 writes nothing, so it cannot feed a jalr
	assign is_upper = ((kind == OP_LUI) || (kind == OP_AUIPC)) && (rd_index != 5'd0);

	// jalr reading the register the previous upper-immediate wrote
	// has a target known at decode, no speculation needed
	assign jalr_fold = jalr && upper_valid && (rs1_index == upper_rd);

	// any valid instruction replaces the fold memory,
	// so only the immediately preceding instruction can fold
	always_ff @(posedge clk) begin
		if (!reset) begin
			upper_valid <= 1'b0;
			upper_rd <= '0;
		end else if (instr_valid) begin
			upper_valid <= is_upper;
			upper_rd <= rd_index;
		end
	end

endmodule

//--- hw/ras_control.sv
// link register hints from the unprivileged spec
// x1 and x5 act as link registers
//
// jal  : push when rd is a link register
// jalr :
//   rd link  rs1 link  rd == rs1   action
//   no       no        -           none
//   no       yes       -           pop
//   yes      no        -           push
//   yes      yes       no          pop then push
//   yes      yes       yes         push
module ras_control
	import ras_pkg::*;
(
	input logic branch,
	input logic jump,
	input logic jalr,
	input logic jalr_fold,

	// misprediction or trap this cycle
	input logic exception,

	input reg_index_t rs1_index,
	input reg_index_t rd_index,

	output logic push,
	output logic pop,
	output logic checkpoint,
	output logic restore_checkpoint
);

	logic rd_link;
	logic rs1_link;
	logic push_hint;
	logic pop_hint;
	logic spec_point;

	// x1 or x5
	assign rd_link = (rd_index == 5'd1) || (rd_index == 5'd5);
	assign rs1_link = (rs1_index == 5'd1) || (rs1_index == 5'd5);

	// every jump that writes a link register is a call
	assign push_hint = jump && rd_link;

	// jalr through a link register returns,
	// unless it writes that same register back (coroutine style push only)
	assign pop_hint = jalr && rs1_link && (!rd_link || (rd_index != rs1_index));

	// conditional branch or a jalr whose target is still a guess
	assign spec_point = branch || (jalr && !jalr_fold);

	// wrong path work this cycle is dropped,
	// and the stack rolls back to the last checkpoint
	assign push = push_hint && !exception;
	assign pop = pop_hint && !exception;
	assign checkpoint = spec_point && !exception;
	assign restore_checkpoint = exception;

endmodule

//--- hw/return_address_stack.sv
`include "ras_settings.svh"

module return_address_stack
	import ras_pkg::*;
(
	input logic clk,
	input logic reset,

	input addr_t address_in,

	// both set means pop first, then push into the freed slot
	input logic push,
	input logic pop,

	// save pointer and count before a speculative point
	input logic checkpoint,
	// roll back, takes priority over checkpoint
	input logic restore_checkpoint,

	// top of stack, predicted return target
	output addr_t address_out,

	output logic empty,
	output logic full,
	// valid entries behind the pointer
	output count_t n_entries
);

	addr_t stack [`RAS_DEPTH];

	// pointer to the next free slot
	depth_t sp;
	// slot holding the top entry
	depth_t sp_top;
	depth_t sp_cp;
	count_t count_cp;

	assign sp_top = sp - depth_t'(1);

	assign empty = (n_entries == '0);
	assign full = (n_entries == count_t'(`RAS_DEPTH));

	// before this cycle's update
	assign address_out = stack[sp_top];

	always_ff @(posedge clk) begin
		if (!reset) begin
			stack <= '{default: '0};
			sp <= '0;
			sp_cp <= '0;
			n_entries <= '0;
			count_cp <= '0;
		end else begin
			// array contents
			// pop+push replaces the top in place
			if (push && pop) begin
				stack[sp_top] <= address_in;
			end else if (pop) begin
				stack[sp_top] <= '0;
			end else if (push) begin
				stack[sp] <= address_in;
			end

			// pointer and counter
			if (restore_checkpoint) begin
				sp <= sp_cp;
				n_entries <= count_cp;
			end else begin
				// snapshot the state before this cycle's push/pop
				if (checkpoint) begin
					sp_cp <= sp;
					count_cp <= n_entries;
				end

				if (push && pop) begin
					// an empty stack just gained the overwritten slot
					if (empty) begin
						n_entries <= n_entries + count_t'(1);
					end
				end else if (pop) begin
					sp <= sp_top;
					// underflow keeps the count at zero
					if (!empty) begin
						n_entries <= n_entries - count_t'(1);
					end
				end else if (push) begin
					// wraps and overwrites the oldest entry when full
					sp <= sp + depth_t'(1);
					if (!full) begin
						n_entries <= n_entries + count_t'(1);
					end
				end
			end
		end
	end

endmodule

//--- hw/ras_unit.sv
module ras_unit
	import ras_pkg::*;
(
	input logic clk,
	input logic reset,

	// one instruction per cycle from fetch
	input logic instr_valid,
	input logic [31:0] instr,
	input addr_t pc,

	// misprediction or trap, rolls the stack back
	input logic exception,

	// this instruction is a return, use ret_target
	output logic ret_predict,
	output addr_t ret_target,

	output logic ras_empty,
	output logic ras_full,
	output count_t ras_entries
);

	// decoded fields
	logic branch;
	logic jump;
	logic jalr;
	logic jalr_fold;
	reg_index_t rs1_index;
	reg_index_t rd_index;
	addr_t link_address;

	// stack commands
	logic push;
	logic pop;
	logic checkpoint;
	logic restore_checkpoint;

	jump_decode decode_i (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.branch(branch),
		.jump(jump),
		.jalr(jalr),
		.jalr_fold(jalr_fold),
		.rs1_index(rs1_index),
		.rd_index(rd_index),
		.link_address(link_address)
	);

	ras_control control_i (
		.branch(branch),
		.jump(jump),
		.jalr(jalr),
		.jalr_fold(jalr_fold),
		.exception(exception),
		.rs1_index(rs1_index),
		.rd_index(rd_index),
		.push(push),
		.pop(pop),
		.checkpoint(checkpoint),
		.restore_checkpoint(restore_checkpoint)
	);

	return_address_stack stack_i (
		.clk(clk),
		.reset(reset),
		.address_in(link_address),
		.push(push),
		.pop(pop),
		.checkpoint(checkpoint),
		.restore_checkpoint(restore_checkpoint),
		.address_out(ret_target),
		.empty(ras_empty),
		.full(ras_full),
		.n_entries(ras_entries)
	);

	// a pop is exactly a predicted return, already masked by exception
	assign ret_predict = pop;

endmodule

//--- verif/ras_tb_model.svh
`ifndef RAS_TB_MODEL_SVH
`define RAS_TB_MODEL_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd12;

// reference stack, pointers kept as plain integers
addr_t m_stack [`RAS_DEPTH];
int m_sp;
int m_count;
int m_sp_cp;
int m_count_cp;
// previous valid instruction was lui/auipc into a real register
logic m_upper_valid;
logic [4:0] m_upper_rd;

function automatic logic lfsr_step();
	logic feedback;
	feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], feedback};
	return feedback;
endfunction

// one lfsr step per bit, msb first
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] value;
	int i;
	value = '0;
	for (i = 0; i < n; i++) begin
		value = {value[30:0], lfsr_step()};
	end
	return value;
endfunction

// mostly x0, x1, x5, sometimes anything
function automatic logic [4:0] pick_reg();
	logic [1:0] sel;
	logic [4:0] r;
	sel = 2'(rand_bits(2));
	case (sel)
		2'd0: r = 5'd0;
		2'd1: r = 5'd1;
		2'd2: r = 5'd5;
		default: r = 5'(rand_bits(5));
	endcase
	return r;
endfunction

// encoders, immediates fixed since the stack ignores them
function automatic logic [31:0] enc_jal(input logic [4:0] rd);
	return {20'h00100, rd, OP_JAL};
endfunction

function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
	return {12'h000, rs1, 3'b000, rd, OP_JALR};
endfunction

// beq x2, x3
function automatic logic [31:0] enc_branch();
	return {7'h00, 5'd3, 5'd2, 3'b000, 5'h08, OP_BRANCH};
endfunction

function automatic logic [31:0] enc_upper(input opcode_t op, input logic [4:0] rd);
	return {20'h12345, rd, op};
endfunction

// addi, stands for any non control instruction
function automatic logic [31:0] enc_other(input logic [4:0] rd, input logic [4:0] rs1);
	return {12'h001, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] random_instr();
	logic [2:0] kind;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [31:0] word;
	kind = 3'(rand_bits(3));
	rd = pick_reg();
	rs1 = pick_reg();
	// jumps weighted double so the stack actually moves
	case (kind)
		3'd0, 3'd1: word = enc_jal(rd);
		3'd2, 3'd3: word = enc_jalr(rd, rs1);
		3'd4: word = enc_branch();
		3'd5: word = enc_upper(OP_LUI, rd);
		3'd6: word = enc_upper(OP_AUIPC, rd);
		default: word = enc_other(rd, rs1);
	endcase
	return word;
endfunction

function automatic logic is_link(input logic [4:0] r);
	return (r == 5'd1) || (r == 5'd5);
endfunction

function automatic void model_reset();
	int i;
	for (i = 0; i < `RAS_DEPTH; i++) begin
		m_stack[i] = '0;
	end
	m_sp = 0;
	m_count = 0;
	m_sp_cp = 0;
	m_count_cp = 0;
	m_upper_valid = 1'b0;
	m_upper_rd = '0;
endfunction

function automatic addr_t model_top();
	return m_stack[(m_sp + `RAS_DEPTH - 1) % `RAS_DEPTH];
endfunction

// expected stack commands for one instruction slot
function automatic void model_commands(input logic valid, input logic [31:0] word,
		input logic exc, output logic push, output logic pop, output logic cp);
	logic [4:0] rd;
	logic [4:0] rs1;
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic folded;
	rd = word[11:7];
	rs1 = word[19:15];
	is_jal = valid && (word[6:0] == OP_JAL);
	is_jalr = valid && (word[6:0] == OP_JALR);
	is_branch = valid && (word[6:0] == OP_BRANCH);
	folded = is_jalr && m_upper_valid && (rs1 == m_upper_rd);
	// calls push, returns pop unless they write the same link register back
	push = !exc && (is_jal || is_jalr) && is_link(rd);
	pop = !exc && is_jalr && is_link(rs1) && !(is_link(rd) && (rd == rs1));
	cp = !exc && (is_branch || (is_jalr && !folded));
endfunction

function automatic void model_step(input logic valid, input logic [31:0] word,
		input addr_t addr, input logic exc);
	logic push;
	logic pop;
	logic cp;
	int top;
	model_commands(valid, word, exc, push, pop, cp);
	top = (m_sp + `RAS_DEPTH - 1) % `RAS_DEPTH;
	if (exc) begin
		m_sp = m_sp_cp;
		m_count = m_count_cp;
	end else begin
		// snapshot is the state before this slot
		if (cp) begin
			m_sp_cp = m_sp;
			m_count_cp = m_count;
		end
		if (push && pop) begin
			m_stack[top] = addr + addr_t'(4);
			if (m_count == 0) begin
				m_count = 1;
			end
		end else if (pop) begin
			m_stack[top] = '0;
			m_sp = top;
			if (m_count > 0) begin
				m_count--;
			end
		end else if (push) begin
			m_stack[m_sp] = addr + addr_t'(4);
			m_sp = (m_sp + 1) % `RAS_DEPTH;
			if (m_count < `RAS_DEPTH) begin
				m_count++;
			end
		end
	end
	// fold memory follows every valid slot, exception or not
	if (valid) begin
		m_upper_valid = ((word[6:0] == OP_LUI) || (word[6:0] == OP_AUIPC)) &&
			(word[11:7] != 5'd0);
		m_upper_rd = word[11:7];
	end
endfunction

`endif

//--- verif/tb_ras_unit.sv
`include "ras_settings.svh"

module tb_ras_unit
	import ras_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;
	localparam int CALL_RUN = 5;
	localparam int OVER_CALLS = `RAS_DEPTH + 4;
	localparam int RANDOM_CYCLES = 2000;
	// cycles per test, in order
	localparam int TEST_CYCLES = 1 + (2 * CALL_RUN + 1) + 7 +
		(OVER_CALLS + `RAS_DEPTH + 4) + 11 + RANDOM_CYCLES;
	localparam int CYCLE_LIMIT = RESET_CYCLES + TEST_CYCLES + 100;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	addr_t pc;
	logic exception;
	logic ret_predict;
	addr_t ret_target;
	logic ras_empty;
	logic ras_full;
	count_t ras_entries;

	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;
	int first_check;
	int first_error;
	addr_t call_pcs [64];

	`include "ras_tb_model.svh"

	ras_unit dut_i (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.exception(exception),
		.ret_predict(ret_predict),
		.ret_target(ret_target),
		.ras_empty(ras_empty),
		.ras_full(ras_full),
		.ras_entries(ras_entries)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// hard stop in case a test never returns
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("FAIL %s expected %0h actual %0h cycle %0d", name, expected, actual,
				cycle_count);
			error_count++;
		end
	endtask

	// drive on the rising edge, compare with the model at the falling edge
	task automatic run_cycle(input logic valid, input logic [31:0] word, input addr_t addr,
			input logic exc);
		logic exp_push;
		logic exp_pop;
		logic exp_cp;
		@(posedge clk);
		instr_valid <= valid;
		instr <= word;
		pc <= addr;
		exception <= exc;
		@(negedge clk);
		model_commands(valid, word, exc, exp_push, exp_pop, exp_cp);
		check_value("ret_predict", 64'(exp_pop), 64'(ret_predict));
		if (exp_pop) begin
			check_value("ret_target", 64'(model_top()), 64'(ret_target));
		end
		check_value("ras_empty", 64'(m_count == 0), 64'(ras_empty));
		check_value("ras_full", 64'(m_count == `RAS_DEPTH), 64'(ras_full));
		check_value("ras_entries", 64'(m_count), 64'(ras_entries));
		model_step(valid, word, addr, exc);
	endtask

	task automatic instr_cycle(input logic [31:0] word, input logic [31:0] addr);
		run_cycle(1'b1, word, addr_t'(addr), 1'b0);
	endtask

	task automatic idle_cycle();
		run_cycle(1'b0, 32'h0, '0, 1'b0);
	endtask

	task automatic begin_test();
		first_check = check_count;
		first_error = error_count;
	endtask

	task automatic report_test(input string name);
		$display("test %-20s %0d checks, %0d errors", name, check_count - first_check,
			error_count - first_error);
	endtask

	initial begin
		int i;
		logic [31:0] word;
		addr_t addr;
		logic valid;
		logic exc;

		reset = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		exception = 1'b0;
		model_reset();
		repeat (RESET_CYCLES) begin
			@(posedge clk);
		end
		reset <= 1'b1;

		begin_test();
		idle_cycle();
		check_value("ras_empty", 64'd1, 64'(ras_empty));
		check_value("ras_entries", 64'd0, 64'(ras_entries));
		check_value("ret_predict", 64'd0, 64'(ret_predict));
		report_test("reset");

		// returns come back in lifo order
		begin_test();
		for (i = 0; i < CALL_RUN; i++) begin
			call_pcs[i] = addr_t'(32'h1000 + 16 * i);
			instr_cycle(enc_jal(5'd1), call_pcs[i]);
		end
		for (i = 0; i < CALL_RUN; i++) begin
			instr_cycle(enc_jalr(5'd0, 5'd1), 32'h2000 + 4 * i);
			check_value("ret_predict", 64'd1, 64'(ret_predict));
			check_value("ret_target", 64'(call_pcs[CALL_RUN - 1 - i] + addr_t'(4)),
				64'(ret_target));
		end
		idle_cycle();
		check_value("ras_empty", 64'd1, 64'(ras_empty));
		report_test("calls_returns");

		begin_test();
		instr_cycle(enc_jal(5'd1), 32'h3000);
		// x5 from x1 swaps the top, count unchanged
		instr_cycle(enc_jalr(5'd5, 5'd1), 32'h3100);
		check_value("ret_predict", 64'd1, 64'(ret_predict));
		check_value("ret_target", 64'h3004, 64'(ret_target));
		check_value("ras_entries", 64'd1, 64'(ras_entries));
		// same link register both sides is a push only
		instr_cycle(enc_jalr(5'd1, 5'd1), 32'h3200);
		check_value("ret_predict", 64'd0, 64'(ret_predict));
		check_value("ras_entries", 64'd1, 64'(ras_entries));
		// no link register at all
		instr_cycle(enc_jalr(5'd0, 5'd6), 32'h3300);
		check_value("ret_predict", 64'd0, 64'(ret_predict));
		check_value("ras_entries", 64'd2, 64'(ras_entries));
		instr_cycle(enc_jalr(5'd0, 5'd1), 32'h3400);
		check_value("ret_target", 64'h3204, 64'(ret_target));
		check_value("ras_entries", 64'd2, 64'(ras_entries));
		instr_cycle(enc_jalr(5'd0, 5'd5), 32'h3500);
		check_value("ret_target", 64'h3104, 64'(ret_target));
		check_value("ras_entries", 64'd1, 64'(ras_entries));
		idle_cycle();
		check_value("ras_entries", 64'd0, 64'(ras_entries));
		report_test("hint_table");

		// oldest entries get overwritten, count saturates
		begin_test();
		for (i = 0; i < OVER_CALLS; i++) begin
			call_pcs[i] = addr_t'(32'h4000 + 4 * i);
			instr_cycle(enc_jal(5'd5), call_pcs[i]);
			check_value("ras_full", 64'(i >= `RAS_DEPTH), 64'(ras_full));
			check_value("ras_entries", 64'((i < `RAS_DEPTH) ? i : `RAS_DEPTH),
				64'(ras_entries));
		end
		for (i = 0; i < `RAS_DEPTH; i++) begin
			instr_cycle(enc_jalr(5'd0, 5'd5), 32'h5000 + 4 * i);
			check_value("ret_target", 64'(call_pcs[OVER_CALLS - 1 - i] + addr_t'(4)),
				64'(ret_target));
		end
		// underflow keeps the count at zero
		for (i = 0; i < 3; i++) begin
			instr_cycle(enc_jalr(5'd0, 5'd5), 32'h5800 + 4 * i);
			check_value("ras_entries", 64'd0, 64'(ras_entries));
			check_value("ras_empty", 64'd1, 64'(ras_empty));
		end
		idle_cycle();
		check_value("ras_entries", 64'd0, 64'(ras_entries));
		report_test("overflow_underflow");

		begin_test();
		instr_cycle(enc_jal(5'd1), 32'h6000);
		instr_cycle(enc_jal(5'd1), 32'h6010);
		// checkpoint at two entries
		instr_cycle(enc_branch(), 32'h6100);
		instr_cycle(enc_jal(5'd1), 32'h6020);
		instr_cycle(enc_jal(5'd1), 32'h6030);
		// folded return, pops without moving the checkpoint
		instr_cycle(enc_upper(OP_AUIPC, 5'd5), 32'h6200);
		instr_cycle(enc_jalr(5'd0, 5'd5), 32'h6204);
		check_value("ret_predict", 64'd1, 64'(ret_predict));
		check_value("ret_target", 64'h6034, 64'(ret_target));
		// squashed return, stack rolls back to the branch
		run_cycle(1'b1, enc_jalr(5'd0, 5'd1), addr_t'(32'h6300), 1'b1);
		check_value("ret_predict", 64'd0, 64'(ret_predict));
		idle_cycle();
		check_value("ras_entries", 64'd2, 64'(ras_entries));
		check_value("ret_target", 64'h6014, 64'(ret_target));
		instr_cycle(enc_jalr(5'd0, 5'd1), 32'h6400);
		check_value("ret_target", 64'h6014, 64'(ret_target));
		instr_cycle(enc_jalr(5'd0, 5'd1), 32'h6404);
		check_value("ret_target", 64'h6004, 64'(ret_target));
		report_test("speculation");

		begin_test();
		for (i = 0; i < RANDOM_CYCLES; i++) begin
			word = random_instr();
			addr = addr_t'(rand_bits(30) << 2);
			valid = (rand_bits(4) != 4'd0);
			exc = (rand_bits(4) == 4'd0);
			run_cycle(valid, word, addr, exc);
		end
		report_test("random");

		$display("total %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+hw
+incdir+verif
hw/ras_pkg.sv
hw/jump_decode.sv
hw/ras_control.sv
hw/return_address_stack.sv
hw/ras_unit.sv
verif/tb_ras_unit.sv

//--- Makefile
TOP = tb_ras_unit
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

obj_dir/V$(TOP): files.f hw/*.sv hw/*.svh verif/*.sv verif/*.svh
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "All tests passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
